//--- logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  //////////////////////////////////////////////////
  // Architectural sizes
  //////////////////////////////////////////////////

  localparam int unsigned NUM_READ_PORTS = 2;
  localparam int unsigned REG_ADDR_W     = 3;
  localparam int unsigned XLEN           = 16;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]       word_t;

  // Opcodes 6 to 15 are unused and decode as NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_ADDI = 4'h3,
    OP_LD   = 4'h4,
    OP_ST   = 4'h5
  } opcode_e;

  // Low 3 bits of imm6 double as rs2
  typedef struct packed {
    opcode_e    opcode;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    logic [5:0] imm6;
  } instr_t;

  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Decoded control fields of the instruction in ID
  typedef struct packed {
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    opcode_e   alu_op;
    logic      use_imm;
    word_t     imm;
  } dec_t;

  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    opcode_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
  } id_ex_pipe_t;

  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    word_t     result;
    word_t     store_data;
  } ex_wb_pipe_t;

  typedef struct packed {
    logic    load_stall;
    fw_sel_e operand_a_fw_sel;
    fw_sel_e operand_b_fw_sel;
  } ctrl_byp_t;

  typedef struct packed {
    logic      rf_we;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

  // ALU of the EX stage, also the address adder for LD and ST
  function automatic word_t alu_exec(input id_ex_pipe_t p);
    case (p.alu_op)
      OP_SUB:  alu_exec = p.operand_a - p.operand_b;
      OP_NOP:  alu_exec = '0;
      default: alu_exec = p.operand_a + p.operand_b;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  wire                  clk,
  input  wire                  reset_i,
  input  logic                 instr_valid_i,
  input  pipe_pkg::instr_t     instr_i,
  input  logic                 hold_i,
  output logic [pipe_pkg::NUM_READ_PORTS-1:0] rf_re_o,
  output pipe_pkg::reg_addr_t  rf_raddr_o [pipe_pkg::NUM_READ_PORTS],
  output pipe_pkg::dec_t       dec_o,
  output logic                 id_valid_o
);

  pipe_pkg::instr_t instr_q;
  logic             valid_q;

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////

  // Held while the controller stalls ID or WB waits for grant
  always_ff @(posedge clk) begin
    if (reset_i) begin
      instr_q <= '0;
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      instr_q <= instr_i;
      valid_q <= instr_valid_i;
    end
  end

  assign id_valid_o = valid_q;

  // Port 0 reads rs1, port 1 reads rs2
  assign rf_raddr_o[0] = instr_q.rs1;
  assign rf_raddr_o[1] = instr_q.imm6[pipe_pkg::REG_ADDR_W-1:0];

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    rf_re_o        = '0;
    dec_o          = '0;
    dec_o.rf_waddr = instr_q.rd;
    // Sign extended 6-bit immediate
    dec_o.imm      = {{(pipe_pkg::XLEN-6){instr_q.imm6[5]}}, instr_q.imm6};
    case (instr_q.opcode)
      pipe_pkg::OP_ADD, pipe_pkg::OP_SUB: begin
        rf_re_o      = 2'b11;
        dec_o.rf_we  = 1'b1;
        dec_o.alu_op = instr_q.opcode;
      end
      pipe_pkg::OP_ADDI: begin
        rf_re_o       = 2'b01;
        dec_o.rf_we   = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.alu_op  = pipe_pkg::OP_ADDI;
      end
      pipe_pkg::OP_LD: begin
        rf_re_o       = 2'b01;
        dec_o.rf_we   = 1'b1;
        dec_o.lsu_en  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.alu_op  = pipe_pkg::OP_LD;
      end
      pipe_pkg::OP_ST: begin
        // Base in rs1, store data in rs2, no write-back
        rf_re_o       = 2'b11;
        dec_o.lsu_en  = 1'b1;
        dec_o.lsu_we  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.alu_op  = pipe_pkg::OP_ST;
      end
      default: begin
        // NOP and unused codes
        dec_o.alu_op = pipe_pkg::OP_NOP;
      end
    endcase
    // Result to r0 still retires but never reaches the bank
    if (instr_q.rd == '0) begin
      dec_o.rf_we = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                 clk,
  input  wire                 reset_i,
  input  pipe_pkg::reg_addr_t raddr_i [pipe_pkg::NUM_READ_PORTS],
  output pipe_pkg::word_t     rdata_o [pipe_pkg::NUM_READ_PORTS],
  input  logic                we_i,
  input  pipe_pkg::reg_addr_t waddr_i,
  input  pipe_pkg::word_t     wdata_i
);

  localparam int unsigned NUM_REGS = 2 ** pipe_pkg::REG_ADDR_W;

  pipe_pkg::word_t regs [NUM_REGS];

  // Write port, r0 never written
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Combinational read ports
  for (genvar p = 0; p < pipe_pkg::NUM_READ_PORTS; p++) begin : gen_read
    assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
  end

  // Decoder already drops write enable for rd == 0
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (reset_i)
    we_i |-> (waddr_i != '0)
  );

endmodule

`default_nettype wire

//--- logic/bypass_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl (
  input  logic [pipe_pkg::NUM_READ_PORTS-1:0] rf_re_id_i,
  input  pipe_pkg::reg_addr_t  rf_raddr_id_i [pipe_pkg::NUM_READ_PORTS],
  input  logic                 id_valid_i,
  input  pipe_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                 wb_ready_i,
  output pipe_pkg::ctrl_byp_t  ctrl_byp_o
);

  // Qualified writers in EX and WB
  logic rf_we_ex;
  logic rf_we_wb;
  logic load_ex;
  logic load_wb;

  // Per read port address hits qualified with the writer
  logic [pipe_pkg::NUM_READ_PORTS-1:0] rd_ex_match;
  logic [pipe_pkg::NUM_READ_PORTS-1:0] rd_wb_match;

  assign rf_we_ex = id_ex_pipe_i.instr_valid && id_ex_pipe_i.rf_we;
  assign rf_we_wb = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we;

  // Loads are the only LSU ops that write the bank
  assign load_ex = rf_we_ex && id_ex_pipe_i.lsu_en;
  assign load_wb = rf_we_wb && ex_wb_pipe_i.lsu_en;

  //////////////////////////////////////////////////
  // Address compare with r0 excluded
  //////////////////////////////////////////////////

  for (genvar i = 0; i < pipe_pkg::NUM_READ_PORTS; i++) begin : gen_match
    logic rd_active;
    // Port is a real read of a nonzero register
    assign rd_active = id_valid_i && rf_re_id_i[i] && |rf_raddr_id_i[i];

    assign rd_ex_match[i] = rd_active && rf_we_ex &&
                            (rf_raddr_id_i[i] == id_ex_pipe_i.rf_waddr);
    assign rd_wb_match[i] = rd_active && rf_we_wb &&
                            (rf_raddr_id_i[i] == ex_wb_pipe_i.rf_waddr);
  end

  //////////////////////////////////////////////////
  // Load-use stall
  //////////////////////////////////////////////////

  // Load in EX has no data yet
  // Load in WB has none until grant
  assign ctrl_byp_o.load_stall = (load_ex && |rd_ex_match) ||
                                 (load_wb && !wb_ready_i && |rd_wb_match);

  //////////////////////////////////////////////////
  // Forward select with EX over WB
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_byp_o.operand_a_fw_sel = pipe_pkg::SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_sel = pipe_pkg::SEL_REGFILE;

    // Older producer first
    if (rd_wb_match[0]) begin
      ctrl_byp_o.operand_a_fw_sel = pipe_pkg::SEL_FW_WB;
    end
    if (rd_wb_match[1]) begin
      ctrl_byp_o.operand_b_fw_sel = pipe_pkg::SEL_FW_WB;
    end

    // Younger producer wins and is never taken for a load without a stall
    if (rd_ex_match[0]) begin
      ctrl_byp_o.operand_a_fw_sel = pipe_pkg::SEL_FW_EX;
    end
    if (rd_ex_match[1]) begin
      ctrl_byp_o.operand_b_fw_sel = pipe_pkg::SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

//--- logic/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire                   clk,
  input  wire                   reset_i,
  input  pipe_pkg::ctrl_byp_t   ctrl_byp_i,
  input  logic                  id_valid_i,
  input  pipe_pkg::dec_t        dec_i,
  input  pipe_pkg::word_t       rf_rdata_i [pipe_pkg::NUM_READ_PORTS],
  input  pipe_pkg::word_t       wb_fw_data_i,
  input  logic                  hold_i,
  output pipe_pkg::id_ex_pipe_t id_ex_pipe_o
);

  pipe_pkg::id_ex_pipe_t id_ex_q;
  pipe_pkg::id_ex_pipe_t id_ex_d;

  pipe_pkg::word_t ex_fw_data;
  pipe_pkg::word_t fw_a;
  pipe_pkg::word_t fw_b;

  // Operand source select
  function automatic pipe_pkg::word_t fw_mux(
    input pipe_pkg::fw_sel_e sel,
    input pipe_pkg::word_t   rf_val,
    input pipe_pkg::word_t   ex_val,
    input pipe_pkg::word_t   wb_val
  );
    case (sel)
      pipe_pkg::SEL_FW_EX: fw_mux = ex_val;
      pipe_pkg::SEL_FW_WB: fw_mux = wb_val;
      default:             fw_mux = rf_val;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Forwarding and next ID/EX
  //////////////////////////////////////////////////

  // ALU result of the instruction now in EX
  assign ex_fw_data = pipe_pkg::alu_exec(id_ex_q);

  assign fw_a = fw_mux(ctrl_byp_i.operand_a_fw_sel, rf_rdata_i[0], ex_fw_data, wb_fw_data_i);
  assign fw_b = fw_mux(ctrl_byp_i.operand_b_fw_sel, rf_rdata_i[1], ex_fw_data, wb_fw_data_i);

  always_comb begin
    // Load stall turns the slot into a bubble
    id_ex_d.instr_valid = id_valid_i && !ctrl_byp_i.load_stall;
    id_ex_d.rf_we       = dec_i.rf_we;
    id_ex_d.rf_waddr    = dec_i.rf_waddr;
    id_ex_d.lsu_en      = dec_i.lsu_en;
    id_ex_d.lsu_we      = dec_i.lsu_we;
    id_ex_d.alu_op      = dec_i.alu_op;
    id_ex_d.operand_a   = fw_a;
    id_ex_d.operand_b   = dec_i.use_imm ? dec_i.imm : fw_b;
    id_ex_d.store_data  = fw_b;
  end

  // Held as a whole while WB waits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q <= '0;
    end else if (!hold_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

`default_nettype wire

//--- logic/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
  parameter int unsigned DMEM_DEPTH = 16
) (
  input  wire                   clk,
  input  wire                   reset_i,
  input  pipe_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                  dmem_gnt_i,
  output pipe_pkg::ex_wb_pipe_t ex_wb_pipe_o,
  output logic                  wb_ready_o,
  output logic                  rf_we_o,
  output pipe_pkg::reg_addr_t   rf_waddr_o,
  output pipe_pkg::word_t       rf_wdata_o,
  output pipe_pkg::word_t       wb_fw_data_o,
  output logic                  retire_valid_o,
  output pipe_pkg::retire_t     retire_o
);

  localparam int unsigned DMEM_AW = $clog2(DMEM_DEPTH);

  pipe_pkg::ex_wb_pipe_t ex_wb_q;
  pipe_pkg::word_t       dmem [DMEM_DEPTH];

  logic               mem_access;
  logic [DMEM_AW-1:0] mem_addr;
  pipe_pkg::word_t    wdata;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  // Instruction stays put until its access is granted
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wb_q <= '0;
    end else if (wb_ready_o) begin
      ex_wb_q.instr_valid <= id_ex_pipe_i.instr_valid;
      ex_wb_q.rf_we       <= id_ex_pipe_i.rf_we;
      ex_wb_q.rf_waddr    <= id_ex_pipe_i.rf_waddr;
      ex_wb_q.lsu_en      <= id_ex_pipe_i.lsu_en;
      ex_wb_q.lsu_we      <= id_ex_pipe_i.lsu_we;
      ex_wb_q.result      <= pipe_pkg::alu_exec(id_ex_pipe_i);
      ex_wb_q.store_data  <= id_ex_pipe_i.store_data;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

  // Data memory address wraps modulo depth
  assign mem_access = ex_wb_q.instr_valid && ex_wb_q.lsu_en;
  assign mem_addr   = ex_wb_q.result[DMEM_AW-1:0];
  assign wb_ready_o = !(mem_access && !dmem_gnt_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_access && ex_wb_q.lsu_we && dmem_gnt_i) begin
      dmem[mem_addr] <= ex_wb_q.store_data;
    end
  end

  // Load data for LD and the ALU result or store address otherwise
  assign wdata = (ex_wb_q.lsu_en && !ex_wb_q.lsu_we) ? dmem[mem_addr] : ex_wb_q.result;

  //////////////////////////////////////////////////
  // Write-back and retire
  //////////////////////////////////////////////////

  assign rf_we_o      = ex_wb_q.instr_valid && ex_wb_q.rf_we && wb_ready_o;
  assign rf_waddr_o   = ex_wb_q.rf_waddr;
  assign rf_wdata_o   = wdata;
  assign wb_fw_data_o = wdata;

  assign retire_valid_o = ex_wb_q.instr_valid && wb_ready_o;
  assign retire_o.rf_we = ex_wb_q.rf_we;
  assign retire_o.rd    = ex_wb_q.rf_waddr;
  assign retire_o.data  = wdata;

  // A waiting access freezes the instruction queued in EX
  a_wait_holds: assert property (
    @(posedge clk) disable iff (reset_i)
    !wb_ready_o |=> $stable(id_ex_pipe_i)
  );

endmodule

`default_nettype wire

//--- logic/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top #(
  parameter int unsigned DMEM_DEPTH = 16
) (
  input  wire               clk,
  input  wire               reset_i,
  input  logic              instr_valid_i,
  input  pipe_pkg::instr_t  instr_i,
  output logic              instr_ready_o,
  input  logic              dmem_gnt_i,
  output logic              retire_valid_o,
  output pipe_pkg::retire_t retire_o
);

  // ID outputs
  logic [pipe_pkg::NUM_READ_PORTS-1:0] rf_re;
  pipe_pkg::reg_addr_t rf_raddr [pipe_pkg::NUM_READ_PORTS];
  pipe_pkg::dec_t      dec;
  logic                id_valid;

  // Register bank
  pipe_pkg::word_t     rf_rdata [pipe_pkg::NUM_READ_PORTS];
  logic                rf_we;
  pipe_pkg::reg_addr_t rf_waddr;
  pipe_pkg::word_t     rf_wdata;

  // Pipeline and control
  pipe_pkg::id_ex_pipe_t id_ex_pipe;
  pipe_pkg::ex_wb_pipe_t ex_wb_pipe;
  pipe_pkg::ctrl_byp_t   ctrl_byp;
  pipe_pkg::word_t       wb_fw_data;
  logic                  wb_ready;
  logic                  id_hold;

  //////////////////////////////////////////////////
  // Stall distribution
  //////////////////////////////////////////////////

  // ID holds on load-use or grant wait, EX only on grant wait
  assign id_hold       = ctrl_byp.load_stall || !wb_ready;
  assign instr_ready_o = !id_hold;

  id_decoder u_id_decoder (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .hold_i        (id_hold),
    .rf_re_o       (rf_re),
    .rf_raddr_o    (rf_raddr),
    .dec_o         (dec),
    .id_valid_o    (id_valid)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset_i (reset_i),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  bypass_ctrl u_bypass_ctrl (
    .rf_re_id_i    (rf_re),
    .rf_raddr_id_i (rf_raddr),
    .id_valid_i    (id_valid),
    .id_ex_pipe_i  (id_ex_pipe),
    .ex_wb_pipe_i  (ex_wb_pipe),
    .wb_ready_i    (wb_ready),
    .ctrl_byp_o    (ctrl_byp)
  );

  ex_stage u_ex_stage (
    .clk          (clk),
    .reset_i      (reset_i),
    .ctrl_byp_i   (ctrl_byp),
    .id_valid_i   (id_valid),
    .dec_i        (dec),
    .rf_rdata_i   (rf_rdata),
    .wb_fw_data_i (wb_fw_data),
    .hold_i       (!wb_ready),
    .id_ex_pipe_o (id_ex_pipe)
  );

  wb_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_wb_stage (
    .clk            (clk),
    .reset_i        (reset_i),
    .id_ex_pipe_i   (id_ex_pipe),
    .dmem_gnt_i     (dmem_gnt_i),
    .ex_wb_pipe_o   (ex_wb_pipe),
    .wb_ready_o     (wb_ready),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .wb_fw_data_o   (wb_fw_data),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

`default_nettype wire

//--- test/retire_checker.sv
`timescale 1ns/1ps
`default_nettype none

module retire_checker #(
  parameter int unsigned STIM_WORDS = 320,
  parameter int unsigned FIELDS     = 5
) (
  input  wire               clk,
  input  wire               reset_i,
  input  logic              instr_valid_i,
  input  logic              instr_ready_i,
  input  logic              dmem_gnt_i,
  input  logic              retire_valid_i,
  input  pipe_pkg::retire_t retire_i,
  input  logic [15:0]       stim_i [STIM_WORDS],
  input  int                num_instr_i,
  output int                retired_o,
  output int                errors_o,
  output int                tests_failed_o,
  output int                tests_done_o
);

  // Group holding the load-use sequence
  localparam int unsigned LOAD_USE_GROUP = 3;

  int   retired;
  int   errors;
  int   accepted;
  int   group_errs;
  int   group_size;
  int   tests_failed;
  int   tests_done;
  logic ready_dropped;

  function automatic string group_name(input int g);
    case (g)
      1:       return "independent ALU";
      2:       return "back-to-back forwarding";
      3:       return "load then dependent use";
      4:       return "store then load";
      5:       return "use while load waits in WB";
      default: return "unnamed";
    endcase
  endfunction

  // Group number of entry k
  function automatic int group_of(input int k);
    return int'(stim_i[FIELDS * k]);
  endfunction

  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
      group_errs++;
    end
  endtask

  task automatic report_group(input int g);
    bit ok;
    ok = (group_errs == 0);
    if (g == LOAD_USE_GROUP && !ready_dropped) begin
      $display("instr_ready_o never dropped for a load-use stall in the load-use group");
      ok = 1'b0;
    end
    $display("test %0d %s: %s, %0d retired, %0d mismatches",
             g, group_name(g), ok ? "ok" : "FAILED", group_size, group_errs);
    tests_done++;
    if (!ok) begin
      tests_failed++;
    end
    group_errs = 0;
    group_size = 0;
  endtask

  //////////////////////////////////////////////////
  // Retire monitor
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    int k;
    if (reset_i) begin
      retired       = 0;
      errors        = 0;
      accepted      = 0;
      group_errs    = 0;
      group_size    = 0;
      tests_failed  = 0;
      tests_done    = 0;
      ready_dropped = 1'b0;
    end else begin
      // With grant high WB is ready and only a load-use stall holds off input
      if (!instr_ready_i && dmem_gnt_i && accepted > 0 &&
          group_of(accepted - 1) == LOAD_USE_GROUP) begin
        ready_dropped = 1'b1;
      end
      if (instr_valid_i && instr_ready_i) begin
        accepted++;
      end

      if (retire_valid_i) begin
        if (retired >= num_instr_i) begin
          $display("Extra retirement at %0d ns after all %0d instructions had retired",
                   $time, num_instr_i);
          errors++;
        end else begin
          k = retired;
          compare_field("retire_o.rf_we", {15'b0, retire_i.rf_we},
                        {15'b0, stim_i[FIELDS * k + 2][0]});
          compare_field("retire_o.rd", {13'b0, retire_i.rd},
                        {13'b0, stim_i[FIELDS * k + 3][2:0]});
          compare_field("retire_o.data", retire_i.data, stim_i[FIELDS * k + 4]);
          group_size++;
          retired++;
          // Last entry of its group
          if (retired == num_instr_i || group_of(retired) != group_of(k)) begin
            report_group(group_of(k));
          end
        end
      end
    end

    retired_o      <= retired;
    errors_o       <= errors;
    tests_failed_o <= tests_failed;
    tests_done_o   <= tests_done;
  end

endmodule

`default_nettype wire

//--- test/tb_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe;

  localparam int unsigned MAX_INSTR      = 64;
  // Words per stimulus line are group, instr, rf_we, rd and data
  localparam int unsigned FIELDS         = 5;
  localparam int unsigned STIM_WORDS     = FIELDS * MAX_INSTR;
  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam int unsigned DMEM_DEPTH     = 16;

  logic              clk = 1'b0;
  logic              reset_i;
  logic              instr_valid_i;
  pipe_pkg::instr_t  instr_i;
  logic              instr_ready_o;
  logic              dmem_gnt_i;
  logic              retire_valid_o;
  pipe_pkg::retire_t retire_o;

  logic [15:0] stim_mem [STIM_WORDS];
  int          num_instr;
  logic [31:0] rng_state;

  // Checker results
  int retired;
  int errors;
  int tests_failed;
  int tests_done;

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////////////////////////
  // DUT and checker
  //////////////////////////////////////////////////

  pipe_top #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) UUT (
    .clk            (clk),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .dmem_gnt_i     (dmem_gnt_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  retire_checker #(
    .STIM_WORDS (STIM_WORDS),
    .FIELDS     (FIELDS)
  ) u_checker (
    .clk            (clk),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_i  (instr_ready_o),
    .dmem_gnt_i     (dmem_gnt_i),
    .retire_valid_i (retire_valid_o),
    .retire_i       (retire_o),
    .stim_i         (stim_mem),
    .num_instr_i    (num_instr),
    .retired_o      (retired),
    .errors_o       (errors),
    .tests_failed_o (tests_failed),
    .tests_done_o   (tests_done)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // Grant high on about three cycles in four
  always @(negedge clk) begin
    rng_state  = xorshift32(rng_state);
    dmem_gnt_i = (rng_state[9:8] != 2'b00);
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int idx;
    int waited;
    bit accepted;
    bit timed_out;
    bit complete_ok;
    int total_failed;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    dmem_gnt_i    = 1'b0;
    rng_state     = 32'd41073;
    num_instr     = 0;
    timed_out     = 1'b0;

    // Unused entries keep the end marker
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim_mem[i] = 16'hFFFF;
    end
    $readmemh("test/stim_input.txt", stim_mem);
    while (num_instr < MAX_INSTR && stim_mem[FIELDS * num_instr] != 16'hFFFF) begin
      num_instr++;
    end
    if (num_instr == 0) begin
      $display("No instructions were read from test/stim_input.txt");
    end

    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // One instruction per handshake and held until taken
    idx = 0;
    while (idx < num_instr && !timed_out) begin
      @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = stim_mem[FIELDS * idx + 1];
      accepted      = 1'b0;
      waited        = 0;
      while (!accepted && !timed_out) begin
        @(posedge clk);
        if (instr_ready_o) begin
          accepted = 1'b1;
        end else begin
          waited++;
          if (waited >= TIMEOUT_CYCLES) begin
            $display("Timeout: instruction %0d was not accepted within %0d cycles",
                     idx, TIMEOUT_CYCLES);
            timed_out = 1'b1;
          end
        end
      end
      idx++;
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
    instr_i       = '0;

    // Drain until every instruction has retired
    waited = 0;
    while (!timed_out && retired < num_instr) begin
      @(posedge clk);
      waited++;
      if (waited >= TIMEOUT_CYCLES && retired < num_instr) begin
        $display("Timeout: only %0d of %0d instructions retired", retired, num_instr);
        timed_out = 1'b1;
      end
    end
    // A few idle cycles so a stray extra strobe gets seen
    repeat (4) @(posedge clk);

    complete_ok = !timed_out && (num_instr > 0) && (retired == num_instr);
    $display("test 6 completeness: %s, %0d of %0d retired",
             complete_ok ? "ok" : "FAILED", retired, num_instr);
    total_failed = tests_failed + (complete_ok ? 0 : 1);
    $display("Summary: %0d tests, %0d failed, %0d mismatches",
             tests_done + 1, total_failed, errors);

    if (total_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/stim_input.txt
// group instr rf_we rd data, all hex; rf_we rd data are the expected retire fields
// Groups 1 ALU, 2 forwarding, 3 load-use, 4 store then load, 5 use while load waits
1 3205 1 1 0005 // ADDI r1, r0, 5
1 343D 1 2 FFFD // ADDI r2, r0, -3
1 361F 1 3 001F // ADDI r3, r0, 31
1 3A20 1 5 FFE0 // ADDI r5, r0, -32
1 1842 1 4 0002 // ADD r4, r1, r2
1 2CC1 1 6 001A // SUB r6, r3, r1
1 3047 0 0 000C // ADDI r0, r1, 7
1 1E06 1 7 001A // ADD r7, r0, r6
1 0000 0 0 0000 // NOP
2 1241 1 1 000A // ADD r1, r1, r1
2 1441 1 2 0014 // ADD r2, r1, r1
2 2642 1 3 FFF6 // SUB r3, r1, r2
2 36C1 1 3 FFF7 // ADDI r3, r3, 1
2 18C2 1 4 000B // ADD r4, r3, r2
2 2B03 1 5 0014 // SUB r5, r4, r3
2 3143 0 0 0017 // ADDI r0, r5, 3
2 1C05 1 6 0014 // ADD r6, r0, r5
3 5006 0 0 0006 // ST r6 -> [r0+6]
3 5007 0 0 0007 // ST r7 -> [r0+7]
3 4206 1 1 0014 // LD r1, [r0+6]
3 1441 1 2 0028 // ADD r2, r1, r1
3 4607 1 3 001A // LD r3, [r0+7]
3 0000 0 0 0000 // NOP
3 28C2 1 4 FFF2 // SUB r4, r3, r2
3 4A72 1 5 0014 // LD r5, [r1-14]
3 3D41 1 6 0015 // ADDI r6, r5, 1
4 5002 0 0 0002 // ST r2 -> [r0+2]
4 4E02 1 7 0028 // LD r7, [r0+2]
4 50C4 0 0 001E // ST r4 -> [r3+4]
4 420E 1 1 FFF2 // LD r1, [r0+14]
4 51C1 0 0 0029 // ST r1 -> [r7+1]
4 4409 1 2 FFF2 // LD r2, [r0+9]
4 1082 0 0 FFE4 // ADD r0, r2, r2
5 4607 1 3 001A // LD r3, [r0+7]
5 0000 0 0 0000 // NOP
5 18C5 1 4 002E // ADD r4, r3, r5
5 4B20 1 5 FFF2 // LD r5, [r4-32]
5 3C09 1 6 0009 // ADDI r6, r0, 9
5 2F46 1 7 FFE9 // SUB r7, r5, r6
5 4202 1 1 0028 // LD r1, [r0+2]
5 5003 0 0 0003 // ST r3 -> [r0+3]
5 1447 1 2 0011 // ADD r2, r1, r7
5 4803 1 4 001A // LD r4, [r0+3]
5 1B02 1 5 002B // ADD r5, r4, r2

//--- compile.f
logic/pipe_pkg.sv
logic/id_decoder.sv
logic/reg_file.sv
logic/bypass_ctrl.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/pipe_top.sv
test/retire_checker.sv
test/tb_pipe.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_pipe
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
